//--- tb.f
common/fc_pkg.sv
common/apb_if.sv
common/l2_bus_if.sv
hw/fc_eu/fc_event_fifo.sv
hw/fc_eu/fc_irq_cntrl.sv
hw/irq_service.sv
hw/fc_subsystem.sv
tests/fc_checker.sv
tests/tb_fc_subsystem.sv

//--- tests/tb_fc_subsystem.sv
//**************************************************************************
// Testbench of the FC subsystem with APB setup, event stimulus and L2 model
// Inputs change on the falling clock edge and every wait has a timeout
// L2 grant and response delays come from a Galois LFSR
//**************************************************************************

`timescale 1ns/10ps

module tb_fc_subsystem;

  import fc_pkg::*;

  localparam int WAIT_LIMIT = 500;

  logic                   clk;
  logic                   rst;
  logic [FC_ADDR_W-1:0]   paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [FC_DATA_W-1:0]   pwdata;
  logic [FC_DATA_W-1:0]   prdata;
  logic                   pready;
  logic                   pslverr;
  logic [FC_N_IRQ-1:0]    events;
  logic                   evt_valid;
  logic [FC_EVT_ID_W-1:0] evt_data;
  logic                   evt_fulln;
  logic                   fetch_en;
  logic                   l2_req;
  logic [FC_ADDR_W-1:0]   l2_add;
  logic                   l2_wen;
  logic [FC_DATA_W-1:0]   l2_wdata;
  logic [FC_BE_W-1:0]     l2_be;
  logic                   l2_gnt;
  logic                   l2_r_valid;
  logic [31:0]            lfsr_q;
  logic [31:0]            rdata;
  logic                   err;
  logic [31:0]            burst;
  logic [7:0]             qbytes [4];
  string                  cur_test;
  int                     err_at_start;
  int                     n_tests;
  int                     n_failed;

  always #2 clk = ~clk;

  fc_subsystem i_fc_subsystem (
    .clk_i              (clk),
    .rst_i              (rst),
    .paddr_i            (paddr),
    .psel_i             (psel),
    .penable_i          (penable),
    .pwrite_i           (pwrite),
    .pwdata_i           (pwdata),
    .prdata_o           (prdata),
    .pready_o           (pready),
    .pslverr_o          (pslverr),
    .events_i           (events),
    .event_fifo_valid_i (evt_valid),
    .event_fifo_data_i  (evt_data),
    .event_fifo_fulln_o (evt_fulln),
    .fetch_en_i         (fetch_en),
    .l2_req_o           (l2_req),
    .l2_add_o           (l2_add),
    .l2_wen_o           (l2_wen),
    .l2_wdata_o         (l2_wdata),
    .l2_be_o            (l2_be),
    .l2_gnt_i           (l2_gnt),
    .l2_r_valid_i       (l2_r_valid)
  );

  fc_checker i_fc_checker (
    .clk_i        (clk),
    .rst_i        (rst),
    .l2_req_i     (l2_req),
    .l2_add_i     (l2_add),
    .l2_wen_i     (l2_wen),
    .l2_wdata_i   (l2_wdata),
    .l2_be_i      (l2_be),
    .l2_gnt_i     (l2_gnt),
    .l2_r_valid_i (l2_r_valid)
  );

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int v);
    int b;
    v = 0;
    for (b = 0; b < n; b++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  //**************************************************************************
  // L2 model grants after 0 to 3 cycles and answers 1 to 2 cycles later
  //**************************************************************************
  always begin : l2_model
    int dly;
    @(negedge clk);
    if (!rst && l2_req) begin
      rand_bits(2, dly);
      repeat (dly) @(negedge clk);
      l2_gnt = 1'b1;
      @(negedge clk);
      l2_gnt = 1'b0;
      rand_bits(1, dly);
      repeat (dly) @(negedge clk);
      l2_r_valid = 1'b1;
      @(negedge clk);
      l2_r_valid = 1'b0;
    end
  end

  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic slverr);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // The access phase ends at the next rising edge
    @(posedge clk);
    i_fc_checker.check_value("pready in access phase", 32'h1, 32'(pready));
    rd     = prdata;
    slverr = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] off, input logic [31:0] data);
    logic [31:0] rd;
    logic        slverr;
    apb_xfer(1'b1, {24'h0, off}, data, rd, slverr);
    i_fc_checker.check_value($sformatf("pslverr on write to %h", off), 32'h0, 32'(slverr));
  endtask

  task automatic reg_check(input logic [7:0] off, input logic [31:0] exp);
    logic [31:0] rd;
    logic        slverr;
    apb_xfer(1'b0, {24'h0, off}, 32'h0, rd, slverr);
    i_fc_checker.check_value($sformatf("pslverr on read of %h", off), 32'h0, 32'(slverr));
    i_fc_checker.check_value($sformatf("read of %h", off), exp, rd);
  endtask

  task automatic pulse_events(input logic [31:0] bits);
    @(negedge clk);
    events = bits;
    @(negedge clk);
    events = '0;
  endtask

  task automatic push_event(input logic [7:0] data);
    int n;
    n = 0;
    @(negedge clk);
    while (!evt_fulln && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!evt_fulln) begin
      i_fc_checker.report_failure("timeout, event queue stayed full");
    end else begin
      evt_valid = 1'b1;
      evt_data  = data;
      @(negedge clk);
      evt_valid = 1'b0;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (i_fc_checker.open_count() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (i_fc_checker.open_count() != 0) begin
      i_fc_checker.report_failure("timeout, expected L2 log records did not all arrive");
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = i_fc_checker.err_cnt;
    i_fc_checker.begin_test(name);
  endtask

  task automatic finish_test();
    int errs;
    errs = i_fc_checker.err_cnt - err_at_start;
    n_tests++;
    if (errs != 0) begin
      n_failed++;
    end
    $display("test %-14s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "failing", errs);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    events       = '0;
    evt_valid    = 1'b0;
    evt_data     = '0;
    fetch_en     = 1'b0;
    l2_gnt       = 1'b0;
    l2_r_valid   = 1'b0;
    lfsr_q       = 32'ha396_5769;
    n_tests      = 0;
    n_failed     = 0;
    err_at_start = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    start_test("registers");
    i_fc_checker.check_value("pslverr after reset", 32'h0, 32'(pslverr));
    reg_check(CTRL, 32'h0);
    reg_write(MASK, 32'h0000_f0f0);
    reg_check(MASK, 32'h0000_f0f0);
    reg_write(MASK_SET, 32'h0000_0f00);
    reg_check(MASK, 32'h0000_fff0);
    reg_write(MASK_CLR, 32'h0000_00f0);
    reg_check(MASK, 32'h0000_ff00);
    reg_write(CTRL, 32'h1);
    reg_check(CTRL, 32'h1);
    reg_write(CTRL, 32'h0);
    reg_write(LOG_BASE, 32'h1000_0100);
    reg_check(LOG_BASE, 32'h1000_0100);
    i_fc_checker.set_base(32'h1000_0100);
    apb_xfer(1'b1, 32'h20, 32'hffff_ffff, rdata, err);
    i_fc_checker.check_value("pslverr on undefined write", 32'h1, 32'(err));
    apb_xfer(1'b0, 32'h24, 32'h0, rdata, err);
    i_fc_checker.check_value("pslverr on undefined read", 32'h1, 32'(err));
    apb_xfer(1'b1, {24'h0, PENDING}, 32'hffff_ffff, rdata, err);
    i_fc_checker.check_value("pslverr on PENDING write", 32'h1, 32'(err));
    reg_check(MASK, 32'h0000_ff00);
    reg_check(PENDING, 32'h0);
    reg_check(CTRL, 32'h0);
    reg_check(LOG_BASE, 32'h1000_0100);
    finish_test();

    start_test("gating");
    reg_write(MASK, 32'hffff_ffff);
    fetch_en = 1'b1;
    // IDs 3 and 7 with the CTRL fetch bit low
    pulse_events(32'h0000_0088);
    idle_cycles(20);
    fetch_en = 1'b0;
    reg_write(CTRL, 32'h1);
    // ID 20 with fetch_en low
    pulse_events(32'h0010_0000);
    idle_cycles(20);
    reg_check(PENDING, 32'h0010_0088);
    i_fc_checker.expect_record(5'd3, 8'h00);
    i_fc_checker.expect_record(5'd7, 8'h00);
    i_fc_checker.expect_record(5'd20, 8'h00);
    fetch_en = 1'b1;
    wait_drained();
    reg_check(PENDING, 32'h0);
    finish_test();

    start_test("masking");
    reg_write(MASK, 32'h0);
    pulse_events(32'h0000_0220);
    idle_cycles(20);
    reg_check(PENDING, 32'h0000_0220);
    reg_write(PEND_CLR, 32'h0000_0200);
    reg_check(PENDING, 32'h0000_0020);
    i_fc_checker.expect_record(5'd5, 8'h00);
    reg_write(MASK_SET, 32'h0000_0220);
    wait_drained();
    idle_cycles(10);
    reg_check(PENDING, 32'h0);
    finish_test();

    start_test("event queue");
    reg_write(CTRL, 32'h0);
    reg_write(MASK_SET, 32'h0000_0800);
    for (int i = 0; i < 4; i++) begin
      qbytes[i] = 8'(8'ha1 + 8'h11 * i);
      push_event(qbytes[i]);
    end
    i_fc_checker.check_value("fulln after four pushes", 32'h0, 32'(evt_fulln));
    reg_check(PENDING, 32'h0000_0800);
    for (int i = 0; i < 4; i++) begin
      i_fc_checker.expect_record(5'(FC_FIFO_PIN), qbytes[i]);
    end
    reg_write(CTRL, 32'h1);
    wait_drained();
    i_fc_checker.check_value("fulln after draining", 32'h1, 32'(evt_fulln));
    finish_test();

    start_test("back-pressure");
    reg_write(CTRL, 32'h0);
    reg_write(LOG_BASE, 32'h2000_0040);
    i_fc_checker.set_base(32'h2000_0040);
    reg_write(MASK, 32'hffff_ffff);
    // IDs 1, 4, 12, 17, 25 and 30 plus four queued events
    burst = 32'h4202_1012;
    pulse_events(burst);
    for (int i = 0; i < 4; i++) begin
      qbytes[i] = 8'(8'h3c + 8'h29 * i);
      push_event(qbytes[i]);
    end
    // Lowest ID first and the queue line repeats until empty
    for (int id = 0; id < FC_N_IRQ; id++) begin
      if (burst[id]) begin
        i_fc_checker.expect_record(5'(id), 8'h00);
      end
      if (id == FC_FIFO_PIN) begin
        for (int j = 0; j < 4; j++) begin
          i_fc_checker.expect_record(5'(id), qbytes[j]);
        end
      end
    end
    reg_write(CTRL, 32'h1);
    wait_drained();
    idle_cycles(20);
    reg_check(PENDING, 32'h0);
    finish_test();

    $display("tests run %0d, tests failing %0d, errors %0d, records seen %0d",
             n_tests, n_failed, i_fc_checker.err_cnt, i_fc_checker.rec_seen);
    if (i_fc_checker.err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

endmodule

//--- tests/fc_checker.sv
//**************************************************************************
// Testbench checker of the FC subsystem L2 log writes
// Expected records are queued by the stimulus in service order
// Flags a second L2 request before r_valid
// Keeps the error count of the whole run
//**************************************************************************

`timescale 1ns/10ps

module fc_checker (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         l2_req_i,
  input  logic [fc_pkg::FC_ADDR_W-1:0] l2_add_i,
  input  logic                         l2_wen_i,
  input  logic [fc_pkg::FC_DATA_W-1:0] l2_wdata_i,
  input  logic [fc_pkg::FC_BE_W-1:0]   l2_be_i,
  input  logic                         l2_gnt_i,
  input  logic                         l2_r_valid_i
);

  import fc_pkg::*;

  logic [FC_IRQ_ID_W-1:0] exp_id_q [$];
  logic [FC_EVT_ID_W-1:0] exp_evt_q [$];
  logic [FC_ADDR_W-1:0]   log_base = '0;
  logic [15:0]            rec_cnt = '0;
  logic                   outstanding = 1'b0;
  string                  test_name = "none";
  int                     err_cnt = 0;
  int                     rec_seen = 0;

  // Record k lands at base plus 4k with k, event byte and ID packed into the data word
  function automatic logic [63:0] ref_record(input logic [15:0] k, input logic [31:0] base,
                                             input logic [4:0] id, input logic [7:0] evt);
    logic [31:0] addr;
    logic [31:0] data;
    addr = base + 32'(k) * 32'd4;
    data = (32'(k) << 16) | (32'(evt) << 8) | 32'(id);
    return {addr, data};
  endfunction

  function automatic int open_count();
    return exp_id_q.size() + (outstanding ? 1 : 0);
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
  endtask

  task automatic set_base(input logic [31:0] base);
    log_base = base;
  endtask

  task automatic expect_record(input logic [4:0] id, input logic [7:0] evt);
    exp_id_q.push_back(id);
    exp_evt_q.push_back(evt);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    err_cnt++;
  endtask

  task automatic check_write();
    logic [63:0] exp;
    logic [4:0]  id;
    logic [7:0]  evt;
    if (exp_id_q.size() == 0) begin
      report_failure($sformatf("unexpected L2 write of %h to address %h", l2_wdata_i, l2_add_i));
    end else begin
      id  = exp_id_q.pop_front();
      evt = exp_evt_q.pop_front();
      exp = ref_record(rec_cnt, log_base, id, evt);
      check_value("L2 address", exp[63:32], l2_add_i);
      check_value("L2 data", exp[31:0], l2_wdata_i);
    end
    check_value("L2 byte enable", 32'hf, 32'(l2_be_i));
    check_value("L2 wen", 32'h0, 32'(l2_wen_i));
    // The engine counts every granted write
    rec_cnt++;
    rec_seen++;
  endtask

  //**************************************************************************
  // L2 bus monitor
  //**************************************************************************
  always @(posedge clk_i) begin
    if (rst_i) begin
      outstanding = 1'b0;
      rec_cnt     = '0;
    end else begin
      if (l2_r_valid_i) begin
        if (!outstanding) begin
          report_failure("r_valid arrived with no write outstanding");
        end
        outstanding = 1'b0;
      end
      if (l2_req_i && outstanding) begin
        report_failure("second L2 request issued before r_valid");
      end
      if (l2_req_i && l2_gnt_i) begin
        check_write();
        outstanding = 1'b1;
      end
    end
  end

endmodule

//--- hw/fc_subsystem.sv
//**************************************************************************
// Fabric controller subsystem, interrupt controller and service engine
// Engine runs only when fetch_en_i and the CTRL fetch bit are both high
//**************************************************************************

`timescale 1ns/10ps

module fc_subsystem (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // APB configuration port
  input  logic [fc_pkg::FC_ADDR_W-1:0]   paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [fc_pkg::FC_DATA_W-1:0]   pwdata_i,
  output logic [fc_pkg::FC_DATA_W-1:0]   prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,
  // Interrupt sources
  input  logic [fc_pkg::FC_N_IRQ-1:0]    events_i,
  input  logic                           event_fifo_valid_i,
  input  logic [fc_pkg::FC_EVT_ID_W-1:0] event_fifo_data_i,
  output logic                           event_fifo_fulln_o,
  input  logic                           fetch_en_i,
  // L2 data port
  output logic                           l2_req_o,
  output logic [fc_pkg::FC_ADDR_W-1:0]   l2_add_o,
  output logic                           l2_wen_o,
  output logic [fc_pkg::FC_DATA_W-1:0]   l2_wdata_o,
  output logic [fc_pkg::FC_BE_W-1:0]     l2_be_o,
  input  logic                           l2_gnt_i,
  input  logic                           l2_r_valid_i
);

  import fc_pkg::*;

  logic                   irq_req;
  logic [FC_IRQ_ID_W-1:0] irq_id;
  logic [FC_EVT_ID_W-1:0] irq_evt;
  logic                   irq_ack;
  logic [FC_IRQ_ID_W-1:0] irq_ack_id;
  logic                   fetch_en_eu;
  logic                   fetch_en_int;
  logic [FC_ADDR_W-1:0]   log_base;

  apb_if    apb_eu ();
  l2_bus_if l2_data ();

  assign fetch_en_int = fetch_en_eu & fetch_en_i;

  //**************************************************************************
  // Plain ports onto bus interfaces
  //**************************************************************************
  assign apb_eu.paddr   = paddr_i;
  assign apb_eu.psel    = psel_i;
  assign apb_eu.penable = penable_i;
  assign apb_eu.pwrite  = pwrite_i;
  assign apb_eu.pwdata  = pwdata_i;
  assign prdata_o       = apb_eu.prdata;
  assign pready_o       = apb_eu.pready;
  assign pslverr_o      = apb_eu.pslverr;

  assign l2_req_o        = l2_data.req;
  assign l2_add_o        = l2_data.add;
  assign l2_wen_o        = l2_data.wen;
  assign l2_wdata_o      = l2_data.wdata;
  assign l2_be_o         = l2_data.be;
  assign l2_data.gnt     = l2_gnt_i;
  assign l2_data.r_valid = l2_r_valid_i;

  fc_irq_cntrl i_fc_eu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .apb         (apb_eu.slave),
    .events_i    (events_i),
    .evt_valid_i (event_fifo_valid_i),
    .evt_data_i  (event_fifo_data_i),
    .evt_fulln_o (event_fifo_fulln_o),
    .irq_req_o   (irq_req),
    .irq_id_o    (irq_id),
    .irq_evt_o   (irq_evt),
    .irq_ack_i   (irq_ack),
    .ack_id_i    (irq_ack_id),
    .fetch_en_o  (fetch_en_eu),
    .log_base_o  (log_base)
  );

  irq_service i_irq_service (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .irq_req_i  (irq_req),
    .irq_id_i   (irq_id),
    .irq_evt_i  (irq_evt),
    .irq_ack_o  (irq_ack),
    .ack_id_o   (irq_ack_id),
    .fetch_en_i (fetch_en_int),
    .log_base_i (log_base),
    .l2         (l2_data.master)
  );

endmodule

//--- hw/irq_service.sv
//**************************************************************************
// Interrupt service engine, one L2 log record per accepted interrupt
// At most one write is outstanding, r_valid ends each record
// Record counter wraps at 2^16, log base is sampled at acknowledge
//**************************************************************************

`timescale 1ns/10ps

module irq_service (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           irq_req_i,
  input  logic [fc_pkg::FC_IRQ_ID_W-1:0] irq_id_i,
  input  logic [fc_pkg::FC_EVT_ID_W-1:0] irq_evt_i,
  output logic                           irq_ack_o,
  output logic [fc_pkg::FC_IRQ_ID_W-1:0] ack_id_o,
  input  logic                           fetch_en_i,
  input  logic [fc_pkg::FC_ADDR_W-1:0]   log_base_i,
  l2_bus_if.master                       l2
);

  import fc_pkg::*;

  svc_state_e              state_q;
  svc_state_e              state_d;
  logic [FC_LOG_CNT_W-1:0] cnt_q;
  logic [FC_IRQ_ID_W-1:0]  id_q;
  logic [FC_EVT_ID_W-1:0]  evt_q;
  logic [FC_ADDR_W-1:0]    base_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (irq_req_i && fetch_en_i) begin
          state_d = ACK;
        end
      end
      ACK: state_d = WR_REQ;
      WR_REQ: begin
        if (l2.gnt) begin
          state_d = WR_RSP;
        end
      end
      WR_RSP: begin
        if (l2.r_valid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == WR_REQ && l2.gnt) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Record fields are frozen here until the write is granted
  always_ff @(posedge clk_i) begin
    if (state_q == ACK) begin
      id_q   <= irq_id_i;
      evt_q  <= irq_evt_i;
      base_q <= log_base_i;
    end
  end

  assign irq_ack_o = (state_q == ACK);
  assign ack_id_o  = irq_id_i;

  //**************************************************************************
  // L2 write request
  //**************************************************************************
  assign l2.req   = (state_q == WR_REQ);
  assign l2.wen   = 1'b0;
  assign l2.be    = '1;
  assign l2.add   = base_q + {{(FC_ADDR_W-FC_LOG_CNT_W-2){1'b0}}, cnt_q, 2'b00};
  assign l2.wdata = {cnt_q, evt_q,
                     {(FC_DATA_W-FC_LOG_CNT_W-FC_EVT_ID_W-FC_IRQ_ID_W){1'b0}}, id_q};

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (l2.req && !l2.gnt) |=> (l2.req && $stable(l2.add) && $stable(l2.wdata)
                             && $stable(l2.be) && $stable(l2.wen)));

endmodule

//--- hw/fc_eu/fc_irq_cntrl.sv
//**************************************************************************
// APB interrupt controller with pending, mask and event queue
// Zero wait states
// Unknown offsets and writes to PENDING raise pslverr
// Line FC_FIFO_PIN is owned by the event queue and reads as not empty
// Request and ID are registered and drop for one cycle after an ack
//**************************************************************************

`timescale 1ns/10ps

module fc_irq_cntrl (
  input  logic                           clk_i,
  input  logic                           rst_i,
  apb_if.slave                           apb,
  input  logic [fc_pkg::FC_N_IRQ-1:0]    events_i,
  input  logic                           evt_valid_i,
  input  logic [fc_pkg::FC_EVT_ID_W-1:0] evt_data_i,
  output logic                           evt_fulln_o,
  output logic                           irq_req_o,
  output logic [fc_pkg::FC_IRQ_ID_W-1:0] irq_id_o,
  output logic [fc_pkg::FC_EVT_ID_W-1:0] irq_evt_o,
  input  logic                           irq_ack_i,
  input  logic [fc_pkg::FC_IRQ_ID_W-1:0] ack_id_i,
  output logic                           fetch_en_o,
  output logic [fc_pkg::FC_ADDR_W-1:0]   log_base_o
);

  import fc_pkg::*;

  logic [FC_N_IRQ-1:0]    mask_q;
  logic [FC_N_IRQ-1:0]    pend_q;
  logic [FC_N_IRQ-1:0]    pend_d;
  logic [FC_N_IRQ-1:0]    pend_eff;
  logic [FC_N_IRQ-1:0]    active;
  logic [FC_N_IRQ-1:0]    events_q;
  logic [FC_N_IRQ-1:0]    ev_rise;
  logic [FC_N_IRQ-1:0]    ack_clr;
  logic [FC_N_IRQ-1:0]    fifo_bit;
  logic                   fetch_q;
  logic [FC_ADDR_W-1:0]   log_base_q;
  logic                   irq_req_q;
  logic [FC_IRQ_ID_W-1:0] irq_id_q;
  logic [FC_EVT_ID_W-1:0] irq_evt_q;
  logic [FC_IRQ_ID_W-1:0] sel_id;
  logic                   sel_valid;
  fc_reg_e                reg_off;
  logic                   reg_err;
  logic                   apb_access;
  logic                   apb_wr;
  logic                   fifo_pop;
  logic                   fifo_not_empty;
  logic [FC_EVT_ID_W-1:0] fifo_head;

  //**************************************************************************
  // APB decode
  //**************************************************************************
  assign reg_off     = fc_reg_e'(apb.paddr[FC_REG_W-1:0]);
  assign apb_access  = apb.psel & apb.penable;
  assign apb_wr      = apb_access & apb.pwrite & ~reg_err;
  assign apb.pready  = 1'b1;
  assign apb.pslverr = apb_access & reg_err;

  always_comb begin
    apb.prdata = '0;
    reg_err    = 1'b0;
    case (reg_off)
      MASK, MASK_SET, MASK_CLR: apb.prdata = mask_q;
      PEND_SET, PEND_CLR:       apb.prdata = pend_eff;
      PENDING: begin
        apb.prdata = pend_eff;
        reg_err    = apb.pwrite;
      end
      CTRL:     apb.prdata = {{(FC_DATA_W-1){1'b0}}, fetch_q};
      LOG_BASE: apb.prdata = log_base_q;
      default:  reg_err = 1'b1;
    endcase
  end

  //**************************************************************************
  // Pending and priority
  //**************************************************************************
  assign fifo_bit = FC_N_IRQ'(1) << FC_FIFO_PIN;
  assign ev_rise  = events_i & ~events_q & ~fifo_bit;
  assign ack_clr  = irq_ack_i ? ((FC_N_IRQ'(1) << ack_id_i) & ~fifo_bit) : '0;
  assign fifo_pop = irq_ack_i & (ack_id_i == FC_IRQ_ID_W'(FC_FIFO_PIN));
  assign pend_eff = (pend_q & ~fifo_bit) | (fifo_not_empty ? fifo_bit : '0);
  assign active   = pend_eff & mask_q;

  always_comb begin
    pend_d = pend_q & ~ack_clr;
    if (apb_wr && reg_off == PEND_CLR) begin
      pend_d = pend_d & ~apb.pwdata;
    end
    if (apb_wr && reg_off == PEND_SET) begin
      pend_d = pend_d | apb.pwdata;
    end
    // Queue line never lives in pend_q
    pend_d = (pend_d | ev_rise) & ~fifo_bit;
  end

  // Lowest index wins
  always_comb begin
    sel_id    = '0;
    sel_valid = 1'b0;
    for (int i = FC_N_IRQ - 1; i >= 0; i--) begin
      if (active[i]) begin
        sel_valid = 1'b1;
        sel_id    = FC_IRQ_ID_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q     <= '0;
      pend_q     <= '0;
      events_q   <= '0;
      fetch_q    <= 1'b0;
      log_base_q <= '0;
      irq_req_q  <= 1'b0;
    end else begin
      events_q  <= events_i;
      pend_q    <= pend_d;
      // Hold request low in the cycle after an acknowledge
      irq_req_q <= sel_valid & ~irq_ack_i;
      if (apb_wr) begin
        case (reg_off)
          MASK:     mask_q <= apb.pwdata;
          MASK_SET: mask_q <= mask_q | apb.pwdata;
          MASK_CLR: mask_q <= mask_q & ~apb.pwdata;
          CTRL:     fetch_q <= apb.pwdata[0];
          LOG_BASE: log_base_q <= {apb.pwdata[FC_ADDR_W-1:2], 2'b00};
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    irq_id_q  <= sel_id;
    irq_evt_q <= (sel_id == FC_IRQ_ID_W'(FC_FIFO_PIN)) ? fifo_head : '0;
  end

  assign irq_req_o  = irq_req_q;
  assign irq_id_o   = irq_id_q;
  assign irq_evt_o  = irq_evt_q;
  assign fetch_en_o = fetch_q;
  assign log_base_o = log_base_q;

  fc_event_fifo i_event_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (evt_valid_i),
    .push_data_i (evt_data_i),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .fulln_o     (evt_fulln_o)
  );

  // The engine must acknowledge the ID that is currently presented
  a_ack_id: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ack_i |-> (ack_id_i == irq_id_o));

  // Every setup phase is followed by a zero wait access phase
  a_apb_access: assert property (@(posedge clk_i) disable iff (rst_i)
    (apb.psel && !apb.penable) |=> (apb.psel && apb.penable && apb.pready));

endmodule

//--- hw/fc_eu/fc_event_fifo.sv
//**************************************************************************
// Four entry queue of peripheral event IDs
// Pushes while full and pops while empty are dropped
// fulln_o is registered, a sender must sample it before pushing
//**************************************************************************

`timescale 1ns/10ps

module fc_event_fifo (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           push_i,
  input  logic [fc_pkg::FC_EVT_ID_W-1:0] push_data_i,
  input  logic                           pop_i,
  output logic [fc_pkg::FC_EVT_ID_W-1:0] head_o,
  output logic                           not_empty_o,
  output logic                           fulln_o
);

  import fc_pkg::*;

  logic [FC_EVT_ID_W-1:0]   mem_q [FC_FIFO_DEPTH];
  logic [FC_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FC_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FC_FIFO_CNT_W-1:0] count_q;
  logic [FC_FIFO_CNT_W-1:0] count_d;
  logic                     fulln_q;
  logic                     do_push;
  logic                     do_pop;

  assign not_empty_o = (count_q != '0);
  assign fulln_o     = fulln_q;
  assign head_o      = mem_q[rd_ptr_q];
  assign do_push     = push_i & fulln_q;
  assign do_pop      = pop_i & not_empty_o;

  always_comb begin
    count_d = count_q;
    if (do_push && !do_pop) begin
      count_d = count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      fulln_q  <= 1'b1;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      fulln_q <= (count_d != FC_FIFO_CNT_W'(FC_FIFO_DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> not_empty_o);

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> fulln_o);

endmodule

//--- common/l2_bus_if.sv
//**************************************************************************
// TCDM style L2 data port, req/gnt address phase and r_valid response
// wen is active low, no read data is carried
//**************************************************************************

`timescale 1ns/10ps

interface l2_bus_if;

  logic                         req;
  logic [fc_pkg::FC_ADDR_W-1:0] add;
  logic                         wen;
  logic [fc_pkg::FC_DATA_W-1:0] wdata;
  logic [fc_pkg::FC_BE_W-1:0]   be;
  logic                         gnt;
  logic                         r_valid;

  modport master (
    output req, add, wen, wdata, be,
    input  gnt, r_valid
  );

  modport slave (
    input  req, add, wen, wdata, be,
    output gnt, r_valid
  );

endinterface

//--- common/apb_if.sv
//**************************************************************************
// APB configuration bus, zero wait state slaves only
//**************************************************************************

`timescale 1ns/10ps

interface apb_if;

  logic [fc_pkg::FC_ADDR_W-1:0] paddr;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [fc_pkg::FC_DATA_W-1:0] pwdata;
  logic [fc_pkg::FC_DATA_W-1:0] prdata;
  logic                         pready;
  logic                         pslverr;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

//--- common/fc_pkg.sv
//**************************************************************************
// Shared widths, register offsets and engine states of the FC subsystem
// All widths are fixed, there is no second configuration
// Register offsets are byte offsets decoded from the low address bits
//**************************************************************************

package fc_pkg;

  // Bus widths for APB and the L2 data port
  localparam int FC_ADDR_W     = 32;
  localparam int FC_DATA_W     = 32;
  localparam int FC_BE_W       = FC_DATA_W / 8;

  // Interrupt lines and IDs
  localparam int FC_N_IRQ      = 32;
  localparam int FC_IRQ_ID_W   = 5;
  localparam int FC_EVT_ID_W   = 8;

  // Peripheral event queue, drives interrupt line FC_FIFO_PIN
  localparam int FC_FIFO_DEPTH = 4;
  localparam int FC_FIFO_PTR_W = 2;
  localparam int FC_FIFO_CNT_W = 3;
  localparam int FC_FIFO_PIN   = 11;

  // Register decode width and log record counter width
  localparam int FC_REG_W      = 8;
  localparam int FC_LOG_CNT_W  = 16;

  // APB register map of the interrupt controller
  typedef enum logic [FC_REG_W-1:0] {
    MASK     = 8'h00,
    MASK_SET = 8'h04,
    MASK_CLR = 8'h08,
    PENDING  = 8'h0C,
    PEND_SET = 8'h10,
    PEND_CLR = 8'h14,
    CTRL     = 8'h18,
    LOG_BASE = 8'h1C
  } fc_reg_e;

  // Interrupt service engine states
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WR_REQ,
    WR_RSP
  } svc_state_e;

endpackage
